//--- rtl/rv_pkg.sv
package rv_pkg;

	// major opcodes of the supported RV32I subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// compressed match patterns, laid out as funct3_b12_[11:7]_[6:2]_quadrant
	// order matters in casez, narrower patterns come first
	localparam logic [15:0] C_ADDI4SPN = 16'b000_?_?????_?????_00;
	localparam logic [15:0] C_LW       = 16'b010_?_?????_?????_00;
	localparam logic [15:0] C_SW       = 16'b110_?_?????_?????_00;
	localparam logic [15:0] C_ADDI     = 16'b000_?_?????_?????_01;
	localparam logic [15:0] C_JAL      = 16'b001_?_?????_?????_01;
	localparam logic [15:0] C_LI       = 16'b010_?_?????_?????_01;
	localparam logic [15:0] C_ADDI16SP = 16'b011_?_00010_?????_01;
	localparam logic [15:0] C_LUI      = 16'b011_?_?????_?????_01;
	localparam logic [15:0] C_SRLI     = 16'b100_?_00???_?????_01;
	localparam logic [15:0] C_SRAI     = 16'b100_?_01???_?????_01;
	localparam logic [15:0] C_ANDI     = 16'b100_?_10???_?????_01;
	localparam logic [15:0] C_SUB      = 16'b100_0_11???_00???_01;
	localparam logic [15:0] C_XOR      = 16'b100_0_11???_01???_01;
	localparam logic [15:0] C_OR       = 16'b100_0_11???_10???_01;
	localparam logic [15:0] C_AND      = 16'b100_0_11???_11???_01;
	localparam logic [15:0] C_J        = 16'b101_?_?????_?????_01;
	localparam logic [15:0] C_BEQZ     = 16'b110_?_?????_?????_01;
	localparam logic [15:0] C_BNEZ     = 16'b111_?_?????_?????_01;
	localparam logic [15:0] C_SLLI     = 16'b000_?_?????_?????_10;
	localparam logic [15:0] C_LWSP     = 16'b010_?_?????_?????_10;
	localparam logic [15:0] C_JR       = 16'b100_0_?????_00000_10;
	localparam logic [15:0] C_MV       = 16'b100_0_?????_?????_10;
	localparam logic [15:0] C_EBREAK   = 16'b100_1_00000_00000_10;
	localparam logic [15:0] C_JALR     = 16'b100_1_?????_00000_10;
	localparam logic [15:0] C_ADD      = 16'b100_1_?????_?????_10;
	localparam logic [15:0] C_SWSP     = 16'b110_?_?????_?????_10;

	// base instruction formats
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word seen through every format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_word_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
	} br_kind_e;

	typedef struct packed {
		alu_op_e     alu_op;
		br_kind_e    br_kind;
		logic        a_is_pc;
		logic        b_is_imm;
		logic [31:0] imm;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic        rd_we;
		logic        is_load;
		logic        is_store;
		logic        is_jalr;
		logic        trap;
		logic        compressed;
	} dec_op_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [4:0]  rd;
		logic        rd_we;
		logic [31:0] value;
		logic        is_load;
		logic        is_store;
		logic [31:0] store_data;
		logic        trap;
	} exec_res_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [4:0]  rd;
		logic        rd_we;
		logic [31:0] rd_data;
		logic        mem_we;
		logic [31:0] mem_addr;
		logic [31:0] mem_wdata;
		logic        trap;
	} retire_t;

endpackage

//--- rtl/comp_instr_decoder.sv
module comp_instr_decoder (
	input  logic [15:0] instruction,
	output logic [31:0] decomp_instruction,
	output logic        reserved
);

	logic [31:0] word;
	logic        res;
	logic [4:0]  rd;
	logic [4:0]  rs2;
	logic [4:0]  rp_a;
	logic [4:0]  rp_b;
	logic [11:0] imm6;
	logic [9:0]  spn_imm;
	logic [11:0] sp16_imm;
	logic [6:0]  lw_off;
	logic [7:0]  lwsp_off;
	logic [7:0]  swsp_off;
	logic [20:0] cj_imm;
	logic [12:0] cb_imm;
	logic        nz6_zero;

	// full register fields and the primed x8..x15 forms
	assign rd   = instruction[11:7];
	assign rs2  = instruction[6:2];
	assign rp_a = {2'b01, instruction[9:7]};
	assign rp_b = {2'b01, instruction[4:2]};

	// immediates, bit scatter per the compressed formats
	assign imm6     = {{6{instruction[12]}}, instruction[12], instruction[6:2]};
	assign nz6_zero = {instruction[12], instruction[6:2]} == 6'd0;
	assign spn_imm  = {instruction[10:7], instruction[12:11], instruction[5], instruction[6], 2'b00};
	assign sp16_imm = {{3{instruction[12]}}, instruction[4:3], instruction[5], instruction[2],
		instruction[6], 4'b0000};
	assign lw_off   = {instruction[5], instruction[12:10], instruction[6], 2'b00};
	assign lwsp_off = {instruction[3:2], instruction[12], instruction[6:4], 2'b00};
	assign swsp_off = {instruction[8:7], instruction[12:9], 2'b00};
	assign cj_imm   = {{10{instruction[12]}}, instruction[8], instruction[10:9], instruction[6],
		instruction[7], instruction[2], instruction[11], instruction[5:3], 1'b0};
	assign cb_imm   = {{5{instruction[12]}}, instruction[6:5], instruction[2],
		instruction[11:10], instruction[4:3], 1'b0};

	always_comb
	begin
		word = '0;
		res  = 1'b0;
		casez (instruction)
			// also catches the all-zero word
			rv_pkg::C_ADDI4SPN:
			begin
				word = {2'b00, spn_imm, 5'd2, 3'b000, rp_b, rv_pkg::OPC_OPIMM};
				res  = spn_imm == 10'd0;
			end
			rv_pkg::C_LW:
				word = {5'b0, lw_off, rp_a, 3'b010, rp_b, rv_pkg::OPC_LOAD};
			rv_pkg::C_SW:
				word = {5'b0, lw_off[6:5], rp_b, rp_a, 3'b010, lw_off[4:0], rv_pkg::OPC_STORE};
			// C.NOP is addi x0 with a zero immediate
			rv_pkg::C_ADDI:
				word = {imm6, rd, 3'b000, rd, rv_pkg::OPC_OPIMM};
			// jal links x1, j links x0
			rv_pkg::C_JAL, rv_pkg::C_J:
				word = {cj_imm[20], cj_imm[10:1], cj_imm[11], cj_imm[19:12],
					{4'b0000, ~instruction[15]}, rv_pkg::OPC_JAL};
			rv_pkg::C_LI:
				word = {imm6, 5'd0, 3'b000, rd, rv_pkg::OPC_OPIMM};
			rv_pkg::C_ADDI16SP:
			begin
				word = {sp16_imm, 5'd2, 3'b000, 5'd2, rv_pkg::OPC_OPIMM};
				res  = nz6_zero;
			end
			rv_pkg::C_LUI:
			begin
				word = {{14{instruction[12]}}, instruction[12], instruction[6:2], rd,
					rv_pkg::OPC_LUI};
				res  = nz6_zero;
			end
			// bit 10 picks the arithmetic shift
			rv_pkg::C_SRLI, rv_pkg::C_SRAI:
			begin
				word = {1'b0, instruction[10], 5'b0, rs2, rp_a, 3'b101, rp_a, rv_pkg::OPC_OPIMM};
				res  = instruction[12];
			end
			rv_pkg::C_ANDI:
				word = {imm6, rp_a, 3'b111, rp_a, rv_pkg::OPC_OPIMM};
			rv_pkg::C_SUB:
				word = {7'b0100000, rp_b, rp_a, 3'b000, rp_a, rv_pkg::OPC_OP};
			rv_pkg::C_XOR:
				word = {7'b0000000, rp_b, rp_a, 3'b100, rp_a, rv_pkg::OPC_OP};
			rv_pkg::C_OR:
				word = {7'b0000000, rp_b, rp_a, 3'b110, rp_a, rv_pkg::OPC_OP};
			rv_pkg::C_AND:
				word = {7'b0000000, rp_b, rp_a, 3'b111, rp_a, rv_pkg::OPC_OP};
			// funct3 bit 13 selects bne over beq
			rv_pkg::C_BEQZ, rv_pkg::C_BNEZ:
				word = {cb_imm[12], cb_imm[10:5], 5'd0, rp_a, {2'b00, instruction[13]},
					cb_imm[4:1], cb_imm[11], rv_pkg::OPC_BRANCH};
			rv_pkg::C_SLLI:
			begin
				word = {7'b0, rs2, rd, 3'b001, rd, rv_pkg::OPC_OPIMM};
				res  = instruction[12];
			end
			rv_pkg::C_LWSP:
				word = {4'b0, lwsp_off, 5'd2, 3'b010, rd, rv_pkg::OPC_LOAD};
			rv_pkg::C_JR:
			begin
				word = {12'b0, rd, 3'b000, 5'd0, rv_pkg::OPC_JALR};
				res  = rd == 5'd0;
			end
			rv_pkg::C_MV:
				word = {7'b0, rs2, 5'd0, 3'b000, rd, rv_pkg::OPC_OP};
			// system opcode, trapped further down
			rv_pkg::C_EBREAK:
				word = 32'h0010_0073;
			rv_pkg::C_JALR:
				word = {12'b0, rd, 3'b000, 5'd1, rv_pkg::OPC_JALR};
			rv_pkg::C_ADD:
				word = {7'b0, rs2, rd, 3'b000, rd, rv_pkg::OPC_OP};
			rv_pkg::C_SWSP:
				word = {4'b0, swsp_off[7:5], rs2, 5'd2, 3'b010, swsp_off[4:0], rv_pkg::OPC_STORE};
			// float, rv64 and other unsupported encodings
			default:
				res = 1'b1;
		endcase
	end

	assign reserved           = res;
	assign decomp_instruction = res ? 32'b0 : word;

endmodule

//--- rtl/instr_decoder.sv
module instr_decoder (
	input  logic            clk,
	input  logic            reset,
	input  logic            instr_valid,
	input  logic [31:0]     instr,
	output logic            dec_valid,
	output rv_pkg::dec_op_t dec_op
);

	logic [31:0]         expanded;
	logic                reserved;
	logic                compressed;
	logic                illegal;
	rv_pkg::instr_word_t w;
	rv_pkg::dec_op_t     op;

	comp_instr_decoder u_expand (
		.instruction        (instr[15:0]),
		.decomp_instruction (expanded),
		.reserved           (reserved)
	);

	assign compressed = instr[1:0] != 2'b11;
	assign w          = compressed ? expanded : instr;

	function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_e sel;
		case (f3)
			3'b000:  sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001:  sel = rv_pkg::ALU_SLL;
			3'b010:  sel = rv_pkg::ALU_SLT;
			3'b011:  sel = rv_pkg::ALU_SLTU;
			3'b100:  sel = rv_pkg::ALU_XOR;
			3'b101:  sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  sel = rv_pkg::ALU_OR;
			default: sel = rv_pkg::ALU_AND;
		endcase
		return sel;
	endfunction

	always_comb
	begin
		op            = '0;
		op.alu_op     = rv_pkg::ALU_ADD;
		op.br_kind    = rv_pkg::BR_NONE;
		op.rs1        = w.r.rs1;
		op.rs2        = w.r.rs2;
		op.rd         = w.r.rd;
		op.compressed = compressed;
		illegal       = 1'b0;
		case (w.r.opcode)
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
			begin
				op.alu_op  = w.r.opcode[5] ? rv_pkg::ALU_PASS_B : rv_pkg::ALU_ADD;
				op.a_is_pc = 1'b1;
				op.b_is_imm = 1'b1;
				op.imm     = {w.u.imm, 12'b0};
				op.rd_we   = 1'b1;
			end
			rv_pkg::OPC_JAL:
			begin
				op.br_kind = rv_pkg::BR_JUMP;
				op.imm     = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11,
					w.j.imm10_1, 1'b0};
				op.rd_we   = 1'b1;
			end
			// target comes out of the alu as rs1 + imm
			rv_pkg::OPC_JALR:
			begin
				op.br_kind  = rv_pkg::BR_JUMP;
				op.is_jalr  = 1'b1;
				op.b_is_imm = 1'b1;
				op.imm      = {{20{w.i.imm[11]}}, w.i.imm};
				op.rd_we    = 1'b1;
				illegal     = w.r.funct3 != 3'b000;
			end
			rv_pkg::OPC_BRANCH:
			begin
				op.imm = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
				case (w.r.funct3)
					3'b000:  op.br_kind = rv_pkg::BR_EQ;
					3'b001:  op.br_kind = rv_pkg::BR_NE;
					3'b100:  op.br_kind = rv_pkg::BR_LT;
					3'b101:  op.br_kind = rv_pkg::BR_GE;
					3'b110:  op.br_kind = rv_pkg::BR_LTU;
					3'b111:  op.br_kind = rv_pkg::BR_GEU;
					default: illegal = 1'b1;
				endcase
			end
			// word access only
			rv_pkg::OPC_LOAD:
			begin
				op.is_load  = 1'b1;
				op.b_is_imm = 1'b1;
				op.imm      = {{20{w.i.imm[11]}}, w.i.imm};
				op.rd_we    = 1'b1;
				illegal     = w.r.funct3 != 3'b010;
			end
			rv_pkg::OPC_STORE:
			begin
				op.is_store = 1'b1;
				op.b_is_imm = 1'b1;
				op.imm      = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
				illegal     = w.r.funct3 != 3'b010;
			end
			rv_pkg::OPC_OPIMM:
			begin
				op.alu_op   = alu_sel(w.r.funct3, w.r.funct3 == 3'b101 && w.r.funct7[5]);
				op.b_is_imm = 1'b1;
				op.imm      = {{20{w.i.imm[11]}}, w.i.imm};
				op.rd_we    = 1'b1;
				illegal     = (w.r.funct3 == 3'b001 && w.r.funct7 != 7'd0) ||
					(w.r.funct3 == 3'b101 && {w.r.funct7[6], w.r.funct7[4:0]} != 6'd0);
			end
			rv_pkg::OPC_OP:
			begin
				op.alu_op = alu_sel(w.r.funct3, w.r.funct7[5]);
				op.rd_we  = 1'b1;
				illegal   = {w.r.funct7[6], w.r.funct7[4:0]} != 6'd0 ||
					(w.r.funct7[5] && w.r.funct3 != 3'b000 && w.r.funct3 != 3'b101);
			end
			default:
				illegal = 1'b1;
		endcase

		// x0 is never written
		if (op.rd == 5'd0)
			op.rd_we = 1'b0;
		if (illegal || (compressed && reserved))
		begin
			op.trap     = 1'b1;
			op.rd_we    = 1'b0;
			op.is_load  = 1'b0;
			op.is_store = 1'b0;
			op.is_jalr  = 1'b0;
			op.br_kind  = rv_pkg::BR_NONE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= instr_valid;
		if (instr_valid)
			dec_op <= op;
	end

endmodule

//--- rtl/exec_unit.sv
module exec_unit #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              dec_valid,
	input  rv_pkg::dec_op_t   dec_op,
	output logic [4:0]        rs1,
	output logic [4:0]        rs2,
	input  logic [31:0]       rs1_data,
	input  logic [31:0]       rs2_data,
	output logic              ex_valid,
	output rv_pkg::exec_res_t ex_res
);

	logic [31:0]       pc;
	logic [31:0]       pc_len;
	logic [31:0]       op_a;
	logic [31:0]       op_b;
	logic [31:0]       alu_out;
	logic [31:0]       next_pc;
	logic              taken;
	rv_pkg::exec_res_t res;

	assign rs1    = dec_op.rs1;
	assign rs2    = dec_op.rs2;
	assign op_a   = dec_op.a_is_pc ? pc : rs1_data;
	assign op_b   = dec_op.b_is_imm ? dec_op.imm : rs2_data;
	assign pc_len = pc + (dec_op.compressed ? 32'd2 : 32'd4);

	always_comb
	begin
		case (dec_op.alu_op)
			rv_pkg::ALU_ADD:  alu_out = op_a + op_b;
			rv_pkg::ALU_SUB:  alu_out = op_a - op_b;
			rv_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
			rv_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
			rv_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
			rv_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
			rv_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
			rv_pkg::ALU_OR:   alu_out = op_a | op_b;
			rv_pkg::ALU_AND:  alu_out = op_a & op_b;
			default:          alu_out = op_b;
		endcase
	end

	// branch compare always on the two register operands
	always_comb
	begin
		case (dec_op.br_kind)
			rv_pkg::BR_EQ:   taken = rs1_data == rs2_data;
			rv_pkg::BR_NE:   taken = rs1_data != rs2_data;
			rv_pkg::BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
			rv_pkg::BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
			rv_pkg::BR_LTU:  taken = rs1_data < rs2_data;
			rv_pkg::BR_GEU:  taken = rs1_data >= rs2_data;
			rv_pkg::BR_JUMP: taken = 1'b1;
			default:         taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (dec_op.is_jalr)
			next_pc = {alu_out[31:1], 1'b0};
		else if (taken)
			next_pc = pc + dec_op.imm;
		else
			next_pc = pc_len;

		res.pc         = pc;
		res.next_pc    = next_pc;
		res.rd         = dec_op.rd;
		res.rd_we      = dec_op.rd_we;
		// link address for jumps, otherwise result or memory address
		res.value      = dec_op.br_kind == rv_pkg::BR_JUMP ? pc_len : alu_out;
		res.is_load    = dec_op.is_load;
		res.is_store   = dec_op.is_store;
		res.store_data = rs2_data;
		res.trap       = dec_op.trap;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc       <= RESET_PC;
			ex_valid <= 1'b0;
		end
		else
		begin
			ex_valid <= dec_valid;
			if (dec_valid)
				pc <= next_pc;
		end
		if (dec_valid)
			ex_res <= res;
	end

endmodule

//--- rtl/result_unit.sv
module result_unit #(
	parameter int DMEM_WORDS = 64
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              ex_valid,
	input  rv_pkg::exec_res_t ex_res,
	input  logic [4:0]        rs1,
	input  logic [4:0]        rs2,
	output logic [31:0]       rs1_data,
	output logic [31:0]       rs2_data,
	output logic              retire_valid,
	output rv_pkg::retire_t   retire
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [31:0]     regs [1:31];
	logic [31:0]     dmem [DMEM_WORDS];
	logic [AW-1:0]   idx;
	logic [31:0]     load_data;
	logic [31:0]     wb_data;
	logic            reg_we;
	logic            mem_we;
	rv_pkg::retire_t rec;

	// word index wraps modulo the memory size
	assign idx       = ex_res.value[AW+1:2];
	assign load_data = dmem[idx];
	assign wb_data   = ex_res.is_load ? load_data : ex_res.value;
	assign reg_we    = ex_valid && ex_res.rd_we && !ex_res.trap && ex_res.rd != 5'd0;
	assign mem_we    = ex_valid && ex_res.is_store && !ex_res.trap;

	// read port with bypass from the write in flight
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		logic [31:0] data;
		if (addr == 5'd0)
			data = '0;
		else if (reg_we && ex_res.rd == addr)
			data = wb_data;
		else
			data = regs[addr];
		return data;
	endfunction

	always_comb
	begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else
		begin
			if (reg_we)
				regs[ex_res.rd] <= wb_data;
			if (mem_we)
				dmem[idx] <= ex_res.store_data;
		end
	end

	// fields of writes that did not happen read as zero
	always_comb
	begin
		rec.pc        = ex_res.pc;
		rec.next_pc   = ex_res.next_pc;
		rec.rd        = reg_we ? ex_res.rd : 5'd0;
		rec.rd_we     = reg_we;
		rec.rd_data   = reg_we ? wb_data : 32'd0;
		rec.mem_we    = mem_we;
		rec.mem_addr  = mem_we ? ex_res.value : 32'd0;
		rec.mem_wdata = mem_we ? ex_res.store_data : 32'd0;
		rec.trap      = ex_res.trap;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			retire_valid <= 1'b0;
		else
			retire_valid <= ex_valid;
		if (ex_valid)
			retire <= rec;
	end

endmodule

//--- rtl/rv_slice_top.sv
module rv_slice_top #(
	parameter logic [31:0] RESET_PC   = 32'h0000_0000,
	parameter int          DMEM_WORDS = 64
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            instr_valid,
	input  logic [31:0]     instr,
	output logic            retire_valid,
	output rv_pkg::retire_t retire
);

	logic              dec_valid;
	rv_pkg::dec_op_t   dec_op;
	logic              ex_valid;
	rv_pkg::exec_res_t ex_res;
	logic [4:0]        rs1;
	logic [4:0]        rs2;
	logic [31:0]       rs1_data;
	logic [31:0]       rs2_data;

	instr_decoder u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec_valid   (dec_valid),
		.dec_op      (dec_op)
	);

	exec_unit #(
		.RESET_PC (RESET_PC)
	) u_exec (
		.clk       (clk),
		.reset     (reset),
		.dec_valid (dec_valid),
		.dec_op    (dec_op),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.ex_valid  (ex_valid),
		.ex_res    (ex_res)
	);

	result_unit #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_result (
		.clk          (clk),
		.reset        (reset),
		.ex_valid     (ex_valid),
		.ex_res       (ex_res),
		.rs1          (rs1),
		.rs2          (rs2),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

endmodule

//--- sim/rv_slice_sva.sv
module rv_slice_sva (
	input logic            clk,
	input logic            reset,
	input logic            instr_valid,
	input logic            retire_valid,
	input rv_pkg::retire_t retire
);

	timeunit 1ns;
	timeprecision 1ps;

	// fixed three cycle latency, both directions
	a_latency_fwd: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> ##3 retire_valid)
		else $error("retire_valid missing three cycles after instr_valid");

	a_latency_back: assert property (@(posedge clk) disable iff (reset)
		retire_valid |-> $past(instr_valid, 3))
		else $error("retire_valid without a matching instr_valid");

	a_reset_quiet: assert property (@(posedge clk)
		$past(reset) |-> !retire_valid)
		else $error("retire_valid high during reset");

	// a trapped instruction writes nothing
	a_trap_no_write: assert property (@(posedge clk) disable iff (reset)
		retire_valid && retire.trap |-> !retire.rd_we && !retire.mem_we)
		else $error("trapped retire record carries a write");

endmodule

bind rv_slice_top rv_slice_sva u_sva (
	.clk          (clk),
	.reset        (reset),
	.instr_valid  (instr_valid),
	.retire_valid (retire_valid),
	.retire       (retire)
);

//--- sim/tb_top.sv
module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] START_PC = 32'h0000_0100;

	logic            clk;
	logic            reset;
	logic            instr_valid;
	logic [31:0]     instr;
	logic            retire_valid;
	rv_pkg::retire_t retire;

	logic [31:0]     seed = 32'h9534;
	int              cyc = 0;
	int              errors = 0;
	int              test_errors = 0;
	int              test_records = 0;
	int              tests_run = 0;
	int              tests_failed = 0;
	bit              timed_out = 0;
	string           test_name;

	// reference state
	logic [31:0]     m_regs [32];
	logic [31:0]     m_mem [64];
	logic [31:0]     m_pc;

	rv_pkg::retire_t exp_q [$];
	int              exp_cyc_q [$];

	rv_slice_top #(
		.RESET_PC   (START_PC),
		.DMEM_WORDS (64)
	) UUT (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] rnd();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	// RVC to RV32I by quadrant and funct3
	function automatic logic [31:0] expand(input logic [15:0] c, output bit bad);
		logic [31:0] w;
		logic [4:0]  rd;
		logic [4:0]  rs2;
		logic [4:0]  pa;
		logic [4:0]  pb;
		logic [11:0] i6;
		logic        nz;
		rd  = c[11:7];
		rs2 = c[6:2];
		pa  = {2'b01, c[9:7]};
		pb  = {2'b01, c[4:2]};
		i6  = {{7{c[12]}}, c[6:2]};
		nz  = {c[12], c[6:2]} != 6'd0;
		w   = '0;
		bad = 0;
		case ({c[1:0], c[15:13]})
			5'b00_000:
			begin
				w   = enc_i({2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00}, 5'd2, 3'b000, pb,
					rv_pkg::OPC_OPIMM);
				bad = c[12:5] == 8'd0;
			end
			5'b00_010: w = enc_i({5'd0, c[5], c[12:10], c[6], 2'b00}, pa, 3'b010, pb,
				rv_pkg::OPC_LOAD);
			5'b00_110: w = enc_s({5'd0, c[5], c[12:10], c[6], 2'b00}, pb, pa);
			5'b01_000: w = enc_i(i6, rd, 3'b000, rd, rv_pkg::OPC_OPIMM);
			5'b01_001, 5'b01_101:
				w = enc_j({{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
					1'b0}, c[15] ? 5'd0 : 5'd1);
			5'b01_010: w = enc_i(i6, 5'd0, 3'b000, rd, rv_pkg::OPC_OPIMM);
			5'b01_011:
			begin
				bad = !nz;
				if (rd == 5'd2)
					w = enc_i({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0}, 5'd2, 3'b000, 5'd2,
						rv_pkg::OPC_OPIMM);
				else
					w = {{14{c[12]}}, c[12], c[6:2], rd, rv_pkg::OPC_LUI};
			end
			5'b01_100:
			begin
				case (c[11:10])
					2'b00: w = enc_i({7'd0, rs2}, pa, 3'b101, pa, rv_pkg::OPC_OPIMM);
					2'b01: w = enc_i({7'h20, rs2}, pa, 3'b101, pa, rv_pkg::OPC_OPIMM);
					2'b10: w = enc_i(i6, pa, 3'b111, pa, rv_pkg::OPC_OPIMM);
					default:
					begin
						case (c[6:5])
							2'b00: w = enc_r(7'h20, pb, pa, 3'b000, pa);
							2'b01: w = enc_r(7'h00, pb, pa, 3'b100, pa);
							2'b10: w = enc_r(7'h00, pb, pa, 3'b110, pa);
							default: w = enc_r(7'h00, pb, pa, 3'b111, pa);
						endcase
					end
				endcase
				// shamt[5] and the rv64 register forms
				bad = c[12] && c[11:10] != 2'b10;
			end
			5'b01_110, 5'b01_111:
				w = enc_b({{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0}, pa,
					{2'b00, c[13]});
			5'b10_000:
			begin
				w   = enc_i({7'd0, rs2}, rd, 3'b001, rd, rv_pkg::OPC_OPIMM);
				bad = c[12];
			end
			5'b10_010: w = enc_i({4'd0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'b010, rd,
				rv_pkg::OPC_LOAD);
			5'b10_100:
			begin
				if (rs2 != 5'd0)
					w = enc_r(7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd);
				else if (rd == 5'd0)
					bad = 1;
				else
					w = enc_i(12'd0, rd, 3'b000, {4'd0, c[12]}, rv_pkg::OPC_JALR);
			end
			5'b10_110: w = enc_s({4'd0, c[8:7], c[12:9], 2'b00}, rs2, 5'd2);
			default: bad = 1;
		endcase
		return w;
	endfunction

	function automatic logic [31:0] alu(input logic [2:0] f3, input bit alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b011: return {31'd0, a < b};
			3'b100: return a ^ b;
			// arithmetic shift fills the vacated top bits with the sign
			3'b101: return alt ? (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0])) :
				a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// runs one strobed word on the reference state and queues its record
	task automatic model_exec(input logic [31:0] word);
		rv_pkg::retire_t r;
		logic [31:0]     w;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     len;
		logic [31:0]     val;
		logic [31:0]     iimm;
		logic [31:0]     addr;
		logic [2:0]      f3;
		logic [6:0]      f7;
		bit              trap;
		bit              wr;
		bit              st;
		bit              take;
		trap = 0;
		if (word[1:0] != 2'b11)
		begin
			w   = expand(word[15:0], trap);
			len = 2;
		end
		else
		begin
			w   = word;
			len = 4;
		end
		f3   = w[14:12];
		f7   = w[31:25];
		a    = m_regs[w[19:15]];
		b    = m_regs[w[24:20]];
		iimm = {{20{w[31]}}, w[31:20]};
		r    = '0;
		r.pc = m_pc;
		r.next_pc = m_pc + len;
		wr   = 0;
		st   = 0;
		val  = 0;
		addr = 0;
		case (w[6:0])
			rv_pkg::OPC_LUI:
			begin
				wr  = 1;
				val = {w[31:12], 12'd0};
			end
			rv_pkg::OPC_AUIPC:
			begin
				wr  = 1;
				val = m_pc + {w[31:12], 12'd0};
			end
			rv_pkg::OPC_JAL:
			begin
				wr  = 1;
				val = m_pc + len;
				r.next_pc = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			rv_pkg::OPC_JALR:
			begin
				trap = trap || f3 != 3'b000;
				wr   = 1;
				val  = m_pc + len;
				r.next_pc = (a + iimm) & 32'hFFFF_FFFE;
			end
			rv_pkg::OPC_BRANCH:
			begin
				case (f3)
					3'b000: take = a == b;
					3'b001: take = a != b;
					3'b100: take = $signed(a) < $signed(b);
					3'b101: take = $signed(a) >= $signed(b);
					3'b110: take = a < b;
					3'b111: take = a >= b;
					default: trap = 1;
				endcase
				if (take && !trap)
					r.next_pc = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			rv_pkg::OPC_LOAD:
			begin
				trap = trap || f3 != 3'b010;
				wr   = 1;
				val  = m_mem[(a + iimm) >> 2 & 63];
			end
			rv_pkg::OPC_STORE:
			begin
				trap = trap || f3 != 3'b010;
				st   = 1;
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
			end
			rv_pkg::OPC_OPIMM:
			begin
				trap = trap || (f3 == 3'b001 && f7 != 0) ||
					(f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
				wr   = 1;
				val  = alu(f3, f3 == 3'b101 && f7 == 7'h20, a, iimm);
			end
			rv_pkg::OPC_OP:
			begin
				trap = trap || (f7 != 7'h00 && f7 != 7'h20) ||
					(f7 == 7'h20 && f3 != 3'b000 && f3 != 3'b101);
				wr   = 1;
				val  = alu(f3, f7 == 7'h20, a, b);
			end
			default: trap = 1;
		endcase
		if (trap)
			r.next_pc = m_pc + len;
		r.trap = trap;
		if (!trap && wr && w[11:7] != 5'd0)
		begin
			r.rd      = w[11:7];
			r.rd_we   = 1;
			r.rd_data = val;
			m_regs[w[11:7]] = val;
		end
		if (!trap && st)
		begin
			r.mem_we    = 1;
			r.mem_addr  = addr;
			r.mem_wdata = b;
			m_mem[addr >> 2 & 63] = b;
		end
		m_pc = r.next_pc;
		exp_q.push_back(r);
		exp_cyc_q.push_back(cyc);
	endtask

	task automatic check(input string name, input logic [191:0] expv,
		input logic [191:0] actv);
		if (expv !== actv)
		begin
			$display("** Error %s: expected %h, actual %h", name, expv, actv);
			errors++;
			test_errors++;
		end
	endtask

	task automatic collect();
		if (retire_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("%s: retire record arrived with no instruction outstanding",
					test_name);
				errors++;
				test_errors++;
			end
			else
			begin
				check(test_name, {24'd0, exp_q.pop_front()}, {24'd0, retire});
				check({test_name, " latency"}, 192'(exp_cyc_q.pop_front() + 3), 192'(cyc));
				test_records++;
			end
		end
	endtask

	// one cycle: sample at the falling edge, then drive
	task automatic step(input bit valid, input logic [31:0] word);
		@(negedge clk);
		collect();
		instr_valid = valid;
		instr       = word;
		if (valid)
			model_exec(word);
	endtask

	task automatic finish_test();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 20)
		begin
			step(0, rnd());
			n++;
		end
		if (exp_q.size() > 0)
		begin
			$display("%s: timeout, %0d retire records never arrived", test_name,
				exp_q.size());
			timed_out = 1;
			test_errors++;
		end
		step(0, 32'd0);
		tests_run++;
		if (test_errors > 0)
			tests_failed++;
		$display("test %s: %0d records, %0d errors", test_name, test_records, test_errors);
		test_errors  = 0;
		test_records = 0;
	endtask

	function automatic logic [31:0] gen_word();
		logic [31:0] w;
		logic [31:0] sel;
		logic [6:0]  opcs [9];
		opcs = '{rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR,
			rv_pkg::OPC_BRANCH, rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_OPIMM,
			rv_pkg::OPC_OP};
		sel = rnd() % 20;
		w   = rnd();
		if (sel < 8)
		begin
			if (w[1:0] == 2'b11)
				w[1] = 1'b0;
		end
		else if (sel < 18)
		begin
			w[6:0] = opcs[rnd() % 9];
			// small register set so dependencies are frequent
			w[11:7]  = 5'(rnd() % 16);
			w[19:15] = 5'(rnd() % 16);
			w[24:20] = 5'(rnd() % 16);
			if (w[6:0] == rv_pkg::OPC_LOAD || w[6:0] == rv_pkg::OPC_STORE)
				w[14:12] = 3'b010;
			if (w[6:0] == rv_pkg::OPC_JALR)
				w[14:12] = 3'b000;
			if (w[6:0] == rv_pkg::OPC_OP || w[6:0] == rv_pkg::OPC_OPIMM)
				w[31:25] = (rnd() % 4 == 0) ? 7'h20 : 7'h00;
		end
		else
		begin
			case (rnd() % 4)
				0: w = 32'd0;
				1: w = 32'h0000_0073;
				2: w = 32'h0ff0_000f;
				default: w = {w[31:15], 3'b000, w[11:7], rv_pkg::OPC_LOAD};
			endcase
		end
		return w;
	endfunction

	initial
	begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = 32'd0;
		m_pc        = START_PC;
		for (int i = 0; i < 32; i++)
			m_regs[i] = 32'd0;
		for (int i = 0; i < 64; i++)
			m_mem[i] = 32'd0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "dependent_chain";
		step(1, enc_i(12'h123, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OPIMM));
		step(1, enc_i(12'h001, 5'd5, 3'b000, 5'd6, rv_pkg::OPC_OPIMM));
		step(1, enc_r(7'h00, 5'd5, 5'd6, 3'b000, 5'd7));
		step(1, enc_s(12'd8, 5'd7, 5'd0));
		step(1, enc_i(12'd8, 5'd0, 3'b010, 5'd9, rv_pkg::OPC_LOAD));
		step(1, enc_r(7'h00, 5'd9, 5'd9, 3'b000, 5'd10));
		step(1, enc_i(12'h005, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_OPIMM));
		step(1, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd11));
		// c.lw x8 from the stored word, then c.add consuming it
		step(1, {16'd0, 16'h4000 | 16'h0400});
		step(1, {16'd0, 16'h9002 | 16'd9 << 7 | 16'd8 << 2});
		finish_test();

		test_name = "random_stream";
		for (int i = 0; i < 1500 && !timed_out; i++)
		begin
			if (rnd() % 5 != 0)
				step(1, gen_word());
			else
				step(0, rnd());
		end
		finish_test();

		test_name = "register_sweep";
		for (int r = 0; r < 32; r++)
			step(1, enc_r(7'h00, 5'd0, r[4:0], 3'b000, r[4:0]));
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tb.f
rtl/rv_pkg.sv
rtl/comp_instr_decoder.sv
rtl/instr_decoder.sv
rtl/exec_unit.sv
rtl/result_unit.sv
rtl/rv_slice_top.sv
sim/rv_slice_sva.sv
sim/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f tb.f
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log
if grep -q "Test completed successfully" sim.log; then
	exit 0
else
	exit 1
fi
